/* rtl/aes_pkg.sv */
package aes_pkg;

  // ***********************************************************
  // Cipher constants
  // ***********************************************************

  localparam logic [3:0] AES_NR = 4'd10;  // Rounds for a 128-bit key.

  // ***********************************************************
  // Register word indices, taken from address bits 5 to 2
  // ***********************************************************

  localparam logic [3:0] REG_CTRL   = 4'd0;
  localparam logic [3:0] REG_PT0    = 4'd1;   // Plaintext, least significant first.
  localparam logic [3:0] REG_KEY0   = 4'd5;   // Key, least significant first.
  localparam logic [3:0] REG_STATUS = 4'd9;
  localparam logic [3:0] REG_CT0    = 4'd10;  // Ciphertext, most significant first.
  localparam logic [3:0] REG_LAST   = 4'd13;

  // ***********************************************************
  // AES block, seen as bytes or as words
  // ***********************************************************

  // Index 0 is the most significant element in both views.
  // Byte 4*c + r is row r of column c.
  typedef union packed {
    logic [0:15][7:0] bytes;
    logic [0:3][31:0] words;
  } aes_block_t;

endpackage

/* rtl/aes_sbox.sv */
`timescale 1ns/1ns

module aes_sbox (
  input  logic [7:0] byte_i,
  output logic [7:0] byte_o
);

  // Multiply in GF(2^8) modulo x^8 + x^4 + x^3 + x + 1.
  function automatic logic [7:0] gf_mul(input logic [7:0] a, input logic [7:0] b);
    logic [7:0] acc;
    logic [7:0] sh;
    acc = 8'h00;
    sh  = a;
    for (int i = 0; i < 8; i++) begin
      if (b[i]) begin
        acc = acc ^ sh;
      end
      sh = {sh[6:0], 1'b0} ^ (sh[7] ? 8'h1b : 8'h00);
    end
    return acc;
  endfunction

  logic [7:0] x2, x3, x6, x7;
  logic [7:0] x14, x15, x30, x31;
  logic [7:0] x62, x63, x126, x127;
  logic [7:0] inv;

  // Inverse is x^254, zero stays zero.
  assign x2   = gf_mul(byte_i, byte_i);
  assign x3   = gf_mul(x2, byte_i);
  assign x6   = gf_mul(x3, x3);
  assign x7   = gf_mul(x6, byte_i);
  assign x14  = gf_mul(x7, x7);
  assign x15  = gf_mul(x14, byte_i);
  assign x30  = gf_mul(x15, x15);
  assign x31  = gf_mul(x30, byte_i);
  assign x62  = gf_mul(x31, x31);
  assign x63  = gf_mul(x62, byte_i);
  assign x126 = gf_mul(x63, x63);
  assign x127 = gf_mul(x126, byte_i);
  assign inv  = gf_mul(x127, x127);

  // Affine transform.
  assign byte_o = inv
                ^ {inv[6:0], inv[7]}
                ^ {inv[5:0], inv[7:6]}
                ^ {inv[4:0], inv[7:5]}
                ^ {inv[3:0], inv[7:4]}
                ^ 8'h63;

endmodule

/* rtl/aes_key_schedule.sv */
`timescale 1ns/1ns

module aes_key_schedule (
  input  logic               wb_clk_i,
  input  logic               load_i,
  input  logic               step_i,
  input  aes_pkg::aes_block_t key_i,
  output aes_pkg::aes_block_t round_key_o
);

  aes_pkg::aes_block_t key_q;
  aes_pkg::aes_block_t key_next;
  logic [7:0]  rcon_q;
  logic [31:0] rot_word;
  logic [7:0]  sub_b [4];
  logic [31:0] temp;

  // RotWord of the last key word.
  assign rot_word = {key_q.bytes[13], key_q.bytes[14], key_q.bytes[15], key_q.bytes[12]};

  for (genvar i = 0; i < 4; i++) begin : g_sub
    aes_sbox sbox_i (
      .byte_i (rot_word[31-8*i -: 8]),
      .byte_o (sub_b[i])
    );
  end

  assign temp = {sub_b[0] ^ rcon_q, sub_b[1], sub_b[2], sub_b[3]};

  // XOR chain across the four words.
  always_comb begin
    key_next.words[0] = key_q.words[0] ^ temp;
    key_next.words[1] = key_q.words[1] ^ key_next.words[0];
    key_next.words[2] = key_q.words[2] ^ key_next.words[1];
    key_next.words[3] = key_q.words[3] ^ key_next.words[2];
  end

  // Next round key is what the running round needs.
  assign round_key_o = key_next;

  always_ff @(posedge wb_clk_i) begin
    if (load_i) begin
      key_q  <= key_i;
      rcon_q <= 8'h01;
    end else if (step_i) begin
      key_q  <= key_next;
      rcon_q <= {rcon_q[6:0], 1'b0} ^ (rcon_q[7] ? 8'h1b : 8'h00);  // Double.
    end
  end

endmodule

/* rtl/aes_round.sv */
`timescale 1ns/1ns

module aes_round (
  input  aes_pkg::aes_block_t state_i,
  input  aes_pkg::aes_block_t round_key_i,
  input  logic               final_i,
  output aes_pkg::aes_block_t state_o
);

  function automatic logic [7:0] xtime(input logic [7:0] a);
    return {a[6:0], 1'b0} ^ (a[7] ? 8'h1b : 8'h00);
  endfunction

  logic [7:0] sub_b [16];
  logic [7:0] shf_b [16];
  logic [7:0] mix_b [16];

  // ***********************************************************
  // SubBytes and ShiftRows
  // ***********************************************************

  for (genvar i = 0; i < 16; i++) begin : g_sub
    aes_sbox sbox_i (
      .byte_i (state_i.bytes[i]),
      .byte_o (sub_b[i])
    );
  end

  // Row r moves left by r columns.
  for (genvar c = 0; c < 4; c++) begin : g_shift_col
    for (genvar r = 0; r < 4; r++) begin : g_shift_row
      assign shf_b[4*c+r] = sub_b[4*((c+r)%4)+r];
    end
  end

  // ***********************************************************
  // MixColumns
  // ***********************************************************

  for (genvar c = 0; c < 4; c++) begin : g_mix
    logic [7:0] a0, a1, a2, a3;
    assign a0 = shf_b[4*c];
    assign a1 = shf_b[4*c+1];
    assign a2 = shf_b[4*c+2];
    assign a3 = shf_b[4*c+3];

    assign mix_b[4*c]   = xtime(a0) ^ xtime(a1) ^ a1 ^ a2 ^ a3;
    assign mix_b[4*c+1] = a0 ^ xtime(a1) ^ xtime(a2) ^ a2 ^ a3;
    assign mix_b[4*c+2] = a0 ^ a1 ^ xtime(a2) ^ xtime(a3) ^ a3;
    assign mix_b[4*c+3] = xtime(a0) ^ a0 ^ a1 ^ a2 ^ xtime(a3);
  end

  // AddRoundKey, no column mixing in the last round.
  always_comb begin
    for (int i = 0; i < 16; i++) begin
      state_o.bytes[i] = (final_i ? shf_b[i] : mix_b[i]) ^ round_key_i.bytes[i];
    end
  end

endmodule

/* rtl/aes_128.sv */
`timescale 1ns/1ns

module aes_128 (
  input  logic               wb_clk_i,
  input  logic               wb_rst_i,
  input  logic               start_i,
  input  aes_pkg::aes_block_t block_i,
  input  aes_pkg::aes_block_t key_i,
  output aes_pkg::aes_block_t ct_o,
  output logic               busy_o,
  output logic               done_o
);

  logic [3:0]          round_q;
  logic                busy_q;
  logic                done_q;
  logic                accept;
  logic                final_round;
  aes_pkg::aes_block_t state_q;
  aes_pkg::aes_block_t round_key;
  aes_pkg::aes_block_t round_out;

  assign accept      = start_i & ~busy_q;  // Start while busy is dropped.
  assign final_round = (round_q == aes_pkg::AES_NR);

  aes_key_schedule key_schedule_i (
    .wb_clk_i    (wb_clk_i),
    .load_i      (accept),
    .step_i      (busy_q),
    .key_i       (key_i),
    .round_key_o (round_key)
  );

  aes_round round_i (
    .state_i     (state_q),
    .round_key_i (round_key),
    .final_i     (final_round),
    .state_o     (round_out)
  );

  // ***********************************************************
  // Round sequencing
  // ***********************************************************

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      round_q <= 4'd0;
      busy_q  <= 1'b0;
      done_q  <= 1'b0;
      state_q <= '0;
    end else if (accept) begin
      state_q <= block_i ^ key_i;  // Initial AddRoundKey.
      round_q <= 4'd1;
      busy_q  <= 1'b1;
      done_q  <= 1'b0;
    end else if (busy_q) begin
      state_q <= round_out;
      if (final_round) begin
        busy_q <= 1'b0;
        done_q <= 1'b1;
      end else begin
        round_q <= round_q + 4'd1;
      end
    end
  end

  assign ct_o   = state_q;
  assign busy_o = busy_q;
  assign done_o = done_q;

endmodule

/* rtl/aes_top.sv */
`timescale 1ns/1ns

module aes_top #(
  parameter int aw = 32
) (
  input  logic          wb_clk_i,
  input  logic          wb_rst_i,
  input  logic [aw-1:0] wb_adr_i,
  input  logic [31:0]   wb_dat_i,
  input  logic [3:0]    wb_sel_i,
  input  logic          wb_we_i,
  input  logic          wb_stb_i,
  input  logic          wb_cyc_i,
  output logic [31:0]   wb_dat_o,
  output logic          wb_ack_o,
  output logic          wb_err_o,
  output logic          int_o
);

  logic [3:0]          idx;
  logic [3:0]          pt_off;
  logic [3:0]          key_off;
  logic [3:0]          ct_off;
  logic                xfer;
  logic                bad;
  logic [31:0]         pt_q  [4];
  logic [31:0]         key_q [4];
  logic                ie_q;
  logic                start_q;
  logic                ack_q;
  logic                err_q;
  logic [31:0]         dat_q;
  logic [31:0]         rd_data;
  aes_pkg::aes_block_t pt_blk;
  aes_pkg::aes_block_t key_blk;
  aes_pkg::aes_block_t ct;
  logic                busy;
  logic                done;

  assign idx     = wb_adr_i[5:2];
  assign pt_off  = idx - aes_pkg::REG_PT0;
  assign key_off = idx - aes_pkg::REG_KEY0;
  assign ct_off  = idx - aes_pkg::REG_CT0;

  // One answer per strobe, the answer cycle itself is not a new transfer.
  assign xfer = wb_stb_i & wb_cyc_i & ~ack_q & ~err_q;
  assign bad  = (idx > aes_pkg::REG_LAST) | (wb_we_i & (idx >= aes_pkg::REG_STATUS));

  // ***********************************************************
  // Register file and bus response
  // ***********************************************************

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      for (int k = 0; k < 4; k++) begin
        pt_q[k]  <= 32'd0;
        key_q[k] <= 32'd0;
      end
      ie_q    <= 1'b0;
      start_q <= 1'b0;
      ack_q   <= 1'b0;
      err_q   <= 1'b0;
      dat_q   <= 32'd0;
    end else begin
      start_q <= 1'b0;
      ack_q   <= xfer & ~bad;
      err_q   <= xfer & bad;
      if (xfer & ~wb_we_i & ~bad) begin
        dat_q <= rd_data;
      end
      if (xfer & wb_we_i & ~bad) begin
        if (idx == aes_pkg::REG_CTRL) begin
          start_q <= wb_dat_i[0];
          ie_q    <= wb_dat_i[1];
        end else if (idx < aes_pkg::REG_KEY0) begin
          pt_q[pt_off[1:0]] <= wb_dat_i;
        end else begin
          key_q[key_off[1:0]] <= wb_dat_i;
        end
      end
    end
  end

  always_comb begin
    case (idx)
      aes_pkg::REG_CTRL:   rd_data = {30'd0, ie_q, busy};
      aes_pkg::REG_STATUS: rd_data = {31'd0, done};
      default: begin
        if (idx < aes_pkg::REG_KEY0) begin
          rd_data = pt_q[pt_off[1:0]];
        end else if (idx < aes_pkg::REG_STATUS) begin
          rd_data = key_q[key_off[1:0]];
        end else begin
          rd_data = ct.words[ct_off[1:0]];  // Most significant word first.
        end
      end
    endcase
  end

  // Word 0 of the block is the last written plaintext or key word.
  always_comb begin
    for (int k = 0; k < 4; k++) begin
      pt_blk.words[3-k]  = pt_q[k];
      key_blk.words[3-k] = key_q[k];
    end
  end

  aes_128 aes_128_i (
    .wb_clk_i (wb_clk_i),
    .wb_rst_i (wb_rst_i),
    .start_i  (start_q),
    .block_i  (pt_blk),
    .key_i    (key_blk),
    .ct_o     (ct),
    .busy_o   (busy),
    .done_o   (done)
  );

  assign wb_dat_o = dat_q;
  assign wb_ack_o = ack_q;
  assign wb_err_o = err_q;
  assign int_o    = done & ie_q;

endmodule

/* verification/aes_top_tb.sv */
`timescale 1ns/1ns

module aes_top_tb;

  localparam int    AW           = 32;
  localparam string PATTERN_FILE = "verification/aes_patterns.txt";

  logic          wb_clk_i = 1'b0;
  logic          wb_rst_i;
  logic [AW-1:0] wb_adr_i;
  logic [31:0]   wb_dat_i;
  logic [3:0]    wb_sel_i;
  logic          wb_we_i;
  logic          wb_stb_i;
  logic          wb_cyc_i;
  logic [31:0]   wb_dat_o;
  logic          wb_ack_o;
  logic          wb_err_o;
  logic          int_o;

  logic [127:0] keys[$];
  logic [127:0] plains[$];
  logic [127:0] ciphers[$];
  logic [31:0]  lfsr = 32'd90136;
  int           checks = 0;
  int           errors = 0;
  int           cycles = 0;
  int           cycle_limit = 500;
  logic         int_seen = 1'b0;

  aes_top #(.aw(AW)) aes_top_i (
    .wb_clk_i (wb_clk_i),
    .wb_rst_i (wb_rst_i),
    .wb_adr_i (wb_adr_i),
    .wb_dat_i (wb_dat_i),
    .wb_sel_i (wb_sel_i),
    .wb_we_i  (wb_we_i),
    .wb_stb_i (wb_stb_i),
    .wb_cyc_i (wb_cyc_i),
    .wb_dat_o (wb_dat_o),
    .wb_ack_o (wb_ack_o),
    .wb_err_o (wb_err_o),
    .int_o    (int_o)
  );

  always #20 wb_clk_i = ~wb_clk_i;

  always @(posedge wb_clk_i) begin
    cycles <= cycles + 1;
    if (cycles >= cycle_limit) begin
      $display("Timeout after %0d cycles. Checks: %0d, errors: %0d", cycles, checks, errors);
      $display("Regression failed");
      $finish;
    end
  end

  always @(negedge wb_clk_i) begin
    if (int_o) begin
      int_seen = 1'b1;
    end
  end

  // ***********************************************************
  // Helpers
  // ***********************************************************

  // Galois LFSR stepped once per bit.
  function automatic logic rand_bit();
    logic b;
    b = lfsr[0];
    lfsr = (lfsr >> 1) ^ (b ? 32'h80200003 : 32'h0);
    return b;
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], rand_bit()};
    end
    return v;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("** Error %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("** Error %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic idle(input int n);
    repeat (n) @(posedge wb_clk_i);
  endtask

  // One bus transfer with the answer sampled on the falling edge.
  task automatic bus_cycle(input logic we, input logic [3:0] idx, input logic [31:0] wdata,
                           output logic [31:0] rdata, output logic ack, output logic err);
    int waited;
    waited = 0;
    ack    = 1'b0;
    err    = 1'b0;
    rdata  = '0;
    @(posedge wb_clk_i);
    wb_adr_i <= {{(AW-6){1'b0}}, idx, 2'b00};
    wb_dat_i <= wdata;
    wb_we_i  <= we;
    wb_stb_i <= 1'b1;
    wb_cyc_i <= 1'b1;
    while (!(ack || err) && waited < 2) begin
      @(negedge wb_clk_i);
      waited++;
      ack   = wb_ack_o;
      err   = wb_err_o;
      rdata = wb_dat_o;
    end
    checks++;
    assert (ack || err) else begin
      errors++;
      $display("No bus response to a %s of word %0d", we ? "write" : "read", idx);
    end
    @(posedge wb_clk_i);
    wb_stb_i <= 1'b0;
    wb_cyc_i <= 1'b0;
    wb_we_i  <= 1'b0;
  endtask

  task automatic write_word(input logic [3:0] idx, input logic [31:0] data);
    logic [31:0] rd;
    logic        ack;
    logic        err;
    bus_cycle(1'b1, idx, data, rd, ack, err);
    check_bit($sformatf("wb_ack_o (write word %0d)", idx), ack, 1'b1);
  endtask

  task automatic read_word(input logic [3:0] idx, output logic [31:0] data);
    logic ack;
    logic err;
    bus_cycle(1'b0, idx, 32'd0, data, ack, err);
    check_bit($sformatf("wb_ack_o (read word %0d)", idx), ack, 1'b1);
  endtask

  // Words go in least significant first.
  task automatic load_block(input int v);
    for (int k = 0; k < 4; k++) begin
      write_word(4'(aes_pkg::REG_KEY0 + k), keys[v][32*k +: 32]);
    end
    for (int k = 0; k < 4; k++) begin
      write_word(4'(aes_pkg::REG_PT0 + k), plains[v][32*k +: 32]);
    end
  endtask

  task automatic wait_done();
    logic [31:0] rd;
    int          t0;
    t0 = cycles;
    rd = '0;
    while (!rd[0] && cycles - t0 <= 20) begin
      read_word(aes_pkg::REG_STATUS, rd);
    end
    checks++;
    assert (rd[0]) else begin
      errors++;
      $display("Done flag not seen within 20 cycles");
    end
  endtask

  task automatic check_cipher(input int v);
    logic [31:0] rd;
    for (int k = 0; k < 4; k++) begin
      read_word(4'(aes_pkg::REG_CT0 + k), rd);
      check_value($sformatf("wb_dat_o (ct word %0d, vector %0d)", k, v), rd,
                  ciphers[v][127-32*k -: 32]);
    end
  endtask

  // ***********************************************************
  // Test sequence
  // ***********************************************************

  initial begin
    int           fd;
    string        line;
    logic [127:0] kv;
    logic [127:0] pv;
    logic [127:0] cv;
    logic [31:0]  rd;
    logic [31:0]  data [8];
    logic         ack;
    logic         err;

    wb_rst_i <= 1'b1;
    wb_adr_i <= '0;
    wb_dat_i <= '0;
    wb_sel_i <= 4'hf;  // Whole words only.
    wb_we_i  <= 1'b0;
    wb_stb_i <= 1'b0;
    wb_cyc_i <= 1'b0;

    fd = $fopen(PATTERN_FILE, "r");
    assert (fd != 0) else begin
      errors++;
      $display("Cannot open pattern file %s", PATTERN_FILE);
    end
    if (fd != 0) begin
      while (!$feof(fd)) begin
        if ($fgets(line, fd) != 0 && $sscanf(line, "%h %h %h", kv, pv, cv) == 3) begin
          keys.push_back(kv);
          plains.push_back(pv);
          ciphers.push_back(cv);
        end
      end
      $fclose(fd);
    end
    cycle_limit = 80 * ciphers.size() + 500;

    repeat (8) @(posedge wb_clk_i);
    wb_rst_i <= 1'b0;

    // Reset values and read-back.
    @(negedge wb_clk_i);
    check_bit("int_o", int_o, 1'b0);
    check_bit("wb_ack_o", wb_ack_o, 1'b0);
    check_bit("wb_err_o", wb_err_o, 1'b0);
    for (int i = 0; i <= int'(aes_pkg::REG_LAST); i++) begin
      read_word(4'(i), rd);
      check_value($sformatf("wb_dat_o (word %0d after reset)", i), rd, 32'd0);
    end
    for (int i = 0; i < 8; i++) begin
      data[i] = rand_bits(32);
      idle(rand_bits(3));
      write_word(4'(int'(aes_pkg::REG_PT0) + i), data[i]);
    end
    for (int i = 0; i < 8; i++) begin
      read_word(4'(int'(aes_pkg::REG_PT0) + i), rd);
      check_value($sformatf("wb_dat_o (word %0d)", i + 1), rd, data[i]);
    end

    // Encryption with the interrupt disabled.
    int_seen = 1'b0;
    for (int v = 0; v < ciphers.size(); v++) begin
      load_block(v);
      idle(rand_bits(3));
      write_word(aes_pkg::REG_CTRL, 32'h1);
      wait_done();
      idle(rand_bits(3));
      check_cipher(v);
    end
    check_bit("int_o seen while disabled", int_seen, 1'b0);

    checks++;
    assert (ciphers.size() >= 2) else begin
      errors++;
      $display("Fewer than two patterns, busy and interrupt tests skipped");
    end
    if (ciphers.size() >= 2) begin
      // Busy window where a second start is dropped.
      load_block(0);
      write_word(aes_pkg::REG_CTRL, 32'h3);
      read_word(aes_pkg::REG_CTRL, rd);
      check_value("wb_dat_o (ctrl while busy)", rd, 32'h3);
      check_bit("int_o", int_o, 1'b0);
      // A restart would pick up this new plaintext word.
      write_word(aes_pkg::REG_PT0, ~plains[0][31:0]);
      write_word(aes_pkg::REG_CTRL, 32'h3);
      wait_done();
      @(negedge wb_clk_i);
      check_bit("int_o", int_o, 1'b1);
      check_cipher(0);

      // New start clears done and the interrupt.
      load_block(1);
      @(negedge wb_clk_i);
      check_bit("int_o", int_o, 1'b1);
      write_word(aes_pkg::REG_CTRL, 32'h3);
      @(negedge wb_clk_i);
      check_bit("int_o", int_o, 1'b0);
      wait_done();
      @(negedge wb_clk_i);
      check_bit("int_o", int_o, 1'b1);
      check_cipher(1);
      write_word(aes_pkg::REG_CTRL, 32'h0);
      @(negedge wb_clk_i);
      check_bit("int_o", int_o, 1'b0);

      // Bus errors.
      for (int i = 14; i < 16; i++) begin
        bus_cycle(1'b0, 4'(i), 32'd0, rd, ack, err);
        check_bit($sformatf("wb_err_o (read word %0d)", i), err, 1'b1);
        check_bit($sformatf("wb_ack_o (read word %0d)", i), ack, 1'b0);
      end
      for (int i = int'(aes_pkg::REG_STATUS); i <= int'(aes_pkg::REG_LAST); i++) begin
        bus_cycle(1'b1, 4'(i), rand_bits(32), rd, ack, err);
        check_bit($sformatf("wb_err_o (write word %0d)", i), err, 1'b1);
        check_bit($sformatf("wb_ack_o (write word %0d)", i), ack, 1'b0);
      end
      read_word(aes_pkg::REG_STATUS, rd);
      check_value("wb_dat_o (status)", rd, 32'h1);
      check_cipher(1);
    end

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

/* verification/aes_patterns.txt */
// Columns: key, plaintext, expected ciphertext; 128-bit hex each.
// FIPS-197 appendix vectors
2b7e151628aed2a6abf7158809cf4f3c 3243f6a8885a308d313198a2e0370734 3925841d02dc09fbdc118597196a0b32
000102030405060708090a0b0c0d0e0f 00112233445566778899aabbccddeeff 69c4e0d86a7b0430d8cdb78070b4c55a
// SP 800-38A ECB-AES128 blocks
2b7e151628aed2a6abf7158809cf4f3c 6bc1bee22e409f96e93d7e117393172a 3ad77bb40d7a3660a89ecaf32466ef97
2b7e151628aed2a6abf7158809cf4f3c ae2d8a571e03ac9c9eb76fac45af8e51 f5d3d58503b9699de785895a96fdbaaf
2b7e151628aed2a6abf7158809cf4f3c 30c81c46a35ce411e5fbc1191a0a52ef 43b1cd7f598ece23881b00e3ed030688
2b7e151628aed2a6abf7158809cf4f3c f69f2445df4f9b17ad2b417be66c3710 7b0c785e27e8ad3f8223207104725dd4
// Known-answer vectors
00000000000000000000000000000000 00000000000000000000000000000000 66e94bd4ef8a2c3b884cfa59ca342b2e
00000000000000000000000000000000 f34481ec3cc627bacd5dc3fb08f273e6 0336763e966d92595a567cc9ce537f5e
00000000000000000000000000000000 80000000000000000000000000000000 3ad78e726c1ec02b7ebfe92b23d9ec34
80000000000000000000000000000000 00000000000000000000000000000000 0edd33d3c621e546455bd8ba1418bec8

/* files.f */
rtl/aes_pkg.sv
rtl/aes_sbox.sv
rtl/aes_key_schedule.sv
rtl/aes_round.sv
rtl/aes_128.sv
rtl/aes_top.sv
verification/aes_top_tb.sv

/* Makefile */
# Verilator flow for the AES-128 peripheral.

VERILATOR ?= verilator
TOP       ?= aes_top_tb
RTL_TOP   ?= aes_top
FILE_LIST ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
PASS_MSG  ?= Regression passed

SOURCES := $(shell cat $(FILE_LIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(RTL_TOP) $(filter rtl/%,$(SOURCES))
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILE_LIST)

$(SIM_BIN): $(SOURCES) $(FILE_LIST)
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILE_LIST)

sim: $(SIM_BIN)
	./$(SIM_BIN) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
